/* logic/pp_pkg.sv */
// stream path shared definitions
// word and block sizing plus the state encodings
// for the ping-pong buffers and the stream adapter

`default_nettype none

package pp_pkg;

  // stream word width
  localparam int DATA_W = 32;

  // block size field on the read side
  // wide enough for far deeper buffers than used here
  localparam int SIZE_W = 24;

  // words per block buffer
  localparam int BLOCK_DEPTH = 16;

  // word index inside one buffer, depth is 2**ADDR_W
  localparam int ADDR_W = 4;

  // life cycle of one block buffer
  typedef enum logic [1:0] {
    BUF_EMPTY,
    BUF_FILLING,
    BUF_FULL,
    BUF_READING
  } buf_state_e;

  // stream adapter FSM
  typedef enum logic [1:0] {
    RD_IDLE,
    RD_STREAM,
    RD_RELEASE
  } rd_state_e;

endpackage

`default_nettype wire

/* logic/ppfifo_rd_if.sv */
// ping-pong FIFO read port
// the FIFO offers a full block, the consumer claims it,
// strobes words out one at a time and drops act to free it

`timescale 1ns/10ps
`default_nettype none

interface ppfifo_rd_if;

  // block waiting to be claimed
  logic                      rdy;
  // consumer owns the block
  logic                      act;
  // words in the offered block
  logic [pp_pkg::SIZE_W-1:0] size;
  // word at the current read index
  logic [pp_pkg::DATA_W-1:0] data;
  // one word consumed
  logic                      stb;

  // FIFO side
  modport source (
    output rdy,
    output size,
    output data,
    input  act,
    input  stb
  );

  // consumer side
  modport sink (
    input  rdy,
    input  size,
    input  data,
    output act,
    output stb
  );

endinterface

`default_nettype wire

/* logic/ping_pong_fifo.sv */
// ping-pong block FIFO
// two block buffers filled alternately from the write port;
// a block closes when full or on commit and is offered to the
// read port in fill order, then freed when the reader drops act

`timescale 1ns/10ps
`default_nettype none

module ping_pong_fifo (
  input  logic                      clk,
  input  logic                      rst,
  // write side
  input  logic                      i_wr_valid,
  input  logic [pp_pkg::DATA_W-1:0] i_wr_data,
  input  logic                      i_wr_commit,
  output logic                      o_wr_ready,
  // read side
  ppfifo_rd_if.source               rd
);

  // block storage, two buffers
  logic [pp_pkg::DATA_W-1:0] mem [2][pp_pkg::BLOCK_DEPTH];

  // per-buffer state and fill count
  pp_pkg::buf_state_e        buf_state [2];
  logic [pp_pkg::ADDR_W:0]   buf_count [2];

  // buffer being written
  logic                      wr_sel;
  // oldest closed buffer, next one to hand over
  logic                      rd_sel;
  // word index within the buffer being read
  logic [pp_pkg::ADDR_W-1:0] rd_idx;

  // write side decode
  logic                      wr_take;
  logic                      wr_full_word;
  logic                      commit_only;
  logic                      wr_close;

  // read side decode
  logic                      rd_claim;
  logic                      rd_release;

  // room only while the write buffer is open
  // once it points at a closed buffer both are occupied
  assign o_wr_ready = (buf_state[wr_sel] == pp_pkg::BUF_EMPTY) ||
                      (buf_state[wr_sel] == pp_pkg::BUF_FILLING);

  assign wr_take = i_wr_valid && o_wr_ready;

  // index all ones means this word fills the block
  assign wr_full_word = &buf_count[wr_sel][pp_pkg::ADDR_W-1:0];

  // bare commit closes only a non-empty open block
  assign commit_only = i_wr_commit && !i_wr_valid &&
                       (buf_state[wr_sel] == pp_pkg::BUF_FILLING);

  // close on the last slot, on commit with data, or on bare commit
  assign wr_close = (wr_take && (wr_full_word || i_wr_commit)) || commit_only;

  // reader takes the offered block
  assign rd_claim = rd.act && (buf_state[rd_sel] == pp_pkg::BUF_FULL);

  // reader let go of the block it held
  assign rd_release = !rd.act && (buf_state[rd_sel] == pp_pkg::BUF_READING);

  // offer the oldest block once it is closed
  assign rd.rdy = (buf_state[rd_sel] == pp_pkg::BUF_FULL);

  // block length, zero extended to the size field
  assign rd.size = {{(pp_pkg::SIZE_W - pp_pkg::ADDR_W - 1){1'b0}}, buf_count[rd_sel]};

  // read word straight from the buffer
  assign rd.data = mem[rd_sel][rd_idx];

  // storage write
  always_ff @(posedge clk) begin
    if (wr_take) begin
      mem[wr_sel][buf_count[wr_sel][pp_pkg::ADDR_W-1:0]] <= i_wr_data;
    end
  end

  // buffer bookkeeping
  // write and read never touch the same buffer in one cycle:
  // the write buffer is open, the read buffer is closed
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int b = 0; b < 2; b++) begin
        buf_state[b] <= pp_pkg::BUF_EMPTY;
        buf_count[b] <= '0;
      end
      wr_sel <= 1'b0;
      rd_sel <= 1'b0;
      rd_idx <= '0;
    end else begin
      // accept a word into the open buffer
      if (wr_take) begin
        buf_count[wr_sel] <= buf_count[wr_sel] + 1'b1;
        buf_state[wr_sel] <= pp_pkg::BUF_FILLING;
      end

      // close the block and move to the other buffer
      if (wr_close) begin
        buf_state[wr_sel] <= pp_pkg::BUF_FULL;
        wr_sel            <= ~wr_sel;
      end

      // block claimed by the reader
      if (rd_claim) begin
        buf_state[rd_sel] <= pp_pkg::BUF_READING;
      end

      // step to the next word
      if (rd.stb) begin
        rd_idx <= rd_idx + 1'b1;
      end

      // free the buffer, next block in fill order
      if (rd_release) begin
        buf_state[rd_sel] <= pp_pkg::BUF_EMPTY;
        buf_count[rd_sel] <= '0;
        rd_sel            <= ~rd_sel;
        rd_idx            <= '0;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/ppfifo_to_axis.sv */
// ping-pong FIFO to AXI-Stream adapter
// claims one block at a time, moves its words into a registered
// stream output that holds under back-pressure, tags the final
// word with last and releases the block once last is taken

`timescale 1ns/10ps
`default_nettype none

module ppfifo_to_axis (
  input  logic                      clk,
  input  logic                      rst,
  // block source
  ppfifo_rd_if.sink                 pp,
  // AXI-Stream master
  input  logic                      i_axis_ready,
  output logic                      o_axis_valid,
  output logic [pp_pkg::DATA_W-1:0] o_axis_data,
  output logic                      o_axis_last
);

  pp_pkg::rd_state_e         state;

  // words moved out of the current block
  logic [pp_pkg::SIZE_W-1:0] word_cnt;

  logic                      out_free;
  logic                      words_left;
  logic                      load_word;
  logic                      last_taken;

  // output register empty or draining this cycle
  assign out_free = !o_axis_valid || i_axis_ready;

  // block not yet fully moved
  assign words_left = (word_cnt != pp.size);

  // pull a word whenever the register can take one
  assign load_word = (state == pp_pkg::RD_STREAM) && out_free && words_left;

  // final word of the block accepted downstream
  assign last_taken = o_axis_valid && o_axis_last && i_axis_ready;

  // strobe in the same cycle as the load
  assign pp.stb = load_word;

  // payload register, frozen while valid waits for ready
  always_ff @(posedge clk) begin
    if (load_word) begin
      o_axis_data <= pp.data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= pp_pkg::RD_IDLE;
      pp.act       <= 1'b0;
      word_cnt     <= '0;
      o_axis_valid <= 1'b0;
      o_axis_last  <= 1'b0;
    end else begin
      // stream output register
      if (load_word) begin
        o_axis_valid <= 1'b1;
        o_axis_last  <= (word_cnt == pp.size - 1'b1);
        word_cnt     <= word_cnt + 1'b1;
      end else if (i_axis_ready) begin
        // word taken, nothing behind it
        o_axis_valid <= 1'b0;
        o_axis_last  <= 1'b0;
      end

      case (state)
        pp_pkg::RD_IDLE: begin
          // claim a waiting block
          if (pp.rdy && !pp.act) begin
            pp.act   <= 1'b1;
            word_cnt <= '0;
            state    <= pp_pkg::RD_STREAM;
          end
        end
        pp_pkg::RD_STREAM: begin
          // hold the block until its last word is gone
          if (last_taken) begin
            pp.act <= 1'b0;
            state  <= pp_pkg::RD_RELEASE;
          end
        end
        pp_pkg::RD_RELEASE: begin
          // one cycle for the FIFO to free the buffer
          state <= pp_pkg::RD_IDLE;
        end
        default: begin
          state <= pp_pkg::RD_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/stream_top.sv */
// stream path top level
// producer words go through the ping-pong block FIFO
// and leave as AXI-Stream with last on each block end

`timescale 1ns/10ps
`default_nettype none

module stream_top (
  input  logic                      clk,
  input  logic                      rst,
  // producer write port
  input  logic                      i_wr_valid,
  input  logic [pp_pkg::DATA_W-1:0] i_wr_data,
  input  logic                      i_wr_commit,
  output logic                      o_wr_ready,
  // AXI-Stream output
  output logic                      o_axis_valid,
  output logic [pp_pkg::DATA_W-1:0] o_axis_data,
  output logic                      o_axis_last,
  input  logic                      i_axis_ready
);

  // block hand-over between FIFO and adapter
  ppfifo_rd_if rd_bus ();

  // write fill and block buffering
  ping_pong_fifo u_fifo (
    .clk         (clk),
    .rst         (rst),
    .i_wr_valid  (i_wr_valid),
    .i_wr_data   (i_wr_data),
    .i_wr_commit (i_wr_commit),
    .o_wr_ready  (o_wr_ready),
    .rd          (rd_bus.source)
  );

  // block drain onto the stream
  ppfifo_to_axis u_to_axis (
    .clk          (clk),
    .rst          (rst),
    .pp           (rd_bus.sink),
    .i_axis_ready (i_axis_ready),
    .o_axis_valid (o_axis_valid),
    .o_axis_data  (o_axis_data),
    .o_axis_last  (o_axis_last)
  );

endmodule

`default_nettype wire

/* verif/stream_checker.sv */
// stream adapter assertions
// AXI-Stream hold rules on the output register and
// the claim and strobe rules of the block hand-over

`timescale 1ns/10ps
`default_nettype none

module stream_checker (
  input logic                      clk,
  input logic                      rst,
  // AXI-Stream side
  input logic                      i_axis_ready,
  input logic                      i_axis_valid,
  input logic [pp_pkg::DATA_W-1:0] i_axis_data,
  input logic                      i_axis_last,
  // block hand-over
  input logic                      i_rdy,
  input logic                      i_act,
  input logic                      i_stb
);

  // stalled word keeps valid up
  a_valid_hold: assert property (@(posedge clk) disable iff (rst)
    i_axis_valid && !i_axis_ready |=> i_axis_valid)
    else $error("valid dropped while ready was low");

  // stalled word keeps its payload and last flag
  a_payload_hold: assert property (@(posedge clk) disable iff (rst)
    i_axis_valid && !i_axis_ready |=> $stable(i_axis_data) && $stable(i_axis_last))
    else $error("data or last changed while ready was low");

  // claim only an offered block
  a_act_needs_rdy: assert property (@(posedge clk) disable iff (rst)
    $rose(i_act) |-> $past(i_rdy))
    else $error("act rose without rdy");

  // words consumed only from a claimed block
  a_stb_in_act: assert property (@(posedge clk) disable iff (rst)
    i_stb |-> i_act)
    else $error("stb outside act");

endmodule

`default_nettype wire

/* verif/tb_stream_top.sv */
// stream path testbench
// random producer writes and sink stalls against a queue model
// of the expected words and their last flags

`timescale 1ns/10ps
`default_nettype none

module tb_stream_top;

  localparam int CLK_PERIOD   = 20;
  localparam int DRIVE_DLY    = 1;
  localparam logic [31:0] SEED = 32'h91c4;
  // sum of the words written over all phases
  localparam int TOTAL_WORDS  = 302;
  localparam int MARGIN_CYC   = 500;
  localparam int WATCHDOG_NS  = (TOTAL_WORDS * 3 + MARGIN_CYC) * CLK_PERIOD;

  // sink behavior
  localparam int READY_ALWAYS = 0;
  localparam int READY_STALL  = 1;
  localparam int READY_HOLD   = 2;

  logic                      clk = 1'b0;
  logic                      rst;
  logic                      i_wr_valid;
  logic [pp_pkg::DATA_W-1:0] i_wr_data;
  logic                      i_wr_commit;
  logic                      o_wr_ready;
  logic                      o_axis_valid;
  logic [pp_pkg::DATA_W-1:0] o_axis_data;
  logic                      o_axis_last;
  logic                      i_axis_ready;

  // expected stream, oldest word first
  logic [pp_pkg::DATA_W-1:0] exp_data [$];
  logic                      exp_last [$];
  // words in the block currently being filled
  int                        blk_words;

  logic [31:0]               stim_state;
  logic [31:0]               ready_state;
  int                        ready_mode;

  stream_top dut (
    .clk          (clk),
    .rst          (rst),
    .i_wr_valid   (i_wr_valid),
    .i_wr_data    (i_wr_data),
    .i_wr_commit  (i_wr_commit),
    .o_wr_ready   (o_wr_ready),
    .o_axis_valid (o_axis_valid),
    .o_axis_data  (o_axis_data),
    .o_axis_last  (o_axis_last),
    .i_axis_ready (i_axis_ready)
  );

  bind ppfifo_to_axis stream_checker u_checker (
    .clk          (clk),
    .rst          (rst),
    .i_axis_ready (i_axis_ready),
    .i_axis_valid (o_axis_valid),
    .i_axis_data  (o_axis_data),
    .i_axis_last  (o_axis_last),
    .i_rdy        (pp.rdy),
    .i_act        (pp.act),
    .i_stb        (pp.stb)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [pp_pkg::DATA_W-1:0] widen_bit(input logic bit_in);
    widen_bit    = '0;
    widen_bit[0] = bit_in;
  endfunction

  // reference model of one write-side cycle
  // a block ends on its BLOCK_DEPTH-th word or on a commit
  function automatic void predict(input logic wr_valid, input logic commit,
                                  input logic [pp_pkg::DATA_W-1:0] data);
    logic blk_end;
    if (wr_valid) begin
      blk_words++;
      blk_end = (blk_words == pp_pkg::BLOCK_DEPTH) || commit;
      exp_data.push_back(data);
      exp_last.push_back(blk_end);
      if (blk_end) begin
        blk_words = 0;
      end
    end else if (commit && blk_words != 0) begin
      // bare commit closes the open block on its newest word
      exp_last[exp_last.size() - 1] = 1'b1;
      blk_words = 0;
    end
  endfunction

  task automatic check_value(input string name, input logic [pp_pkg::DATA_W-1:0] expected,
                             input logic [pp_pkg::DATA_W-1:0] actual);
    if (actual !== expected) begin
      $display("Fail at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      $display("Simulation finished: FAIL");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // sink ready, changed just after each rising edge
  always @(posedge clk) begin
    #DRIVE_DLY;
    ready_state = xorshift32(ready_state);
    case (ready_mode)
      READY_STALL: i_axis_ready = (ready_state[1:0] != 2'b00);
      READY_HOLD:  i_axis_ready = 1'b0;
      default:     i_axis_ready = 1'b1;
    endcase
  end

  // mid-cycle sampling, handshakes complete at the next rising edge
  always @(negedge clk) begin
    if (rst) begin
      exp_data.delete();
      exp_last.delete();
      blk_words = 0;
    end else begin
      if (o_axis_valid && i_axis_ready) begin
        if (exp_data.size() == 0) begin
          $display("Stream produced a word at %0t ns with none expected", $time);
          $display("Simulation finished: FAIL");
          $fatal(1, "unexpected stream word");
        end else begin
          check_value("o_axis_data", exp_data.pop_front(), o_axis_data);
          check_value("o_axis_last", widen_bit(exp_last.pop_front()), widen_bit(o_axis_last));
        end
      end
      if (i_wr_valid && o_wr_ready) begin
        predict(1'b1, i_wr_commit, i_wr_data);
      end else if (!i_wr_valid && i_wr_commit) begin
        predict(1'b0, 1'b1, i_wr_data);
      end
    end
  end

  task automatic tick();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) tick();
  endtask

  // hold the word until the FIFO has room
  task automatic send_word(input logic [pp_pkg::DATA_W-1:0] data, input logic commit);
    logic taken;
    i_wr_valid  = 1'b1;
    i_wr_data   = data;
    i_wr_commit = commit;
    taken       = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = o_wr_ready;
      tick();
    end
    i_wr_valid  = 1'b0;
    i_wr_commit = 1'b0;
  endtask

  task automatic bare_commit();
    i_wr_commit = 1'b1;
    tick();
    i_wr_commit = 1'b0;
  endtask

  // random words, gaps and about 1 in 8 commits
  task automatic run_words(input int count, input int max_gap, input logic with_commits);
    logic commit;
    int   gap;
    for (int n = 0; n < count; n++) begin
      stim_state = xorshift32(stim_state);
      commit     = with_commits && (stim_state[10:8] == 3'd0);
      send_word(stim_state, commit);
      stim_state = xorshift32(stim_state);
      gap        = int'(stim_state[7:0]) % (max_gap + 1);
      if (with_commits && stim_state[18:16] == 3'd0 && gap > 0) begin
        bare_commit();
        gap--;
      end
      idle(gap);
    end
  endtask

  task automatic wait_drain();
    while (exp_data.size() != 0) begin
      tick();
    end
    idle(4);
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    idle(3);
    rst = 1'b0;
  endtask

  task automatic check_idle_outputs();
    @(negedge clk);
    check_value("o_axis_valid", widen_bit(1'b0), widen_bit(o_axis_valid));
    check_value("o_axis_last", widen_bit(1'b0), widen_bit(o_axis_last));
    check_value("o_wr_ready", widen_bit(1'b1), widen_bit(o_wr_ready));
    tick();
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired at %0t ns, the stream stalled", $time);
    $display("Simulation finished: FAIL");
    $fatal(1, "watchdog timeout");
  end

  initial begin
    rst          = 1'b1;
    i_wr_valid   = 1'b0;
    i_wr_data    = '0;
    i_wr_commit  = 1'b0;
    i_axis_ready = 1'b1;
    blk_words    = 0;
    stim_state   = SEED;
    ready_state  = xorshift32(SEED);
    ready_mode   = READY_ALWAYS;
    idle(3);
    rst = 1'b0;

    // quiet outputs out of reset
    repeat (3) check_idle_outputs();

    // three full blocks, sink always ready
    run_words(48, 0, 1'b0);
    wait_drain();

    // commit on an empty block gives no output
    bare_commit();
    // early commits with and without data
    run_words(64, 2, 1'b1);
    bare_commit();
    wait_drain();

    // random sink stalls
    ready_mode = READY_STALL;
    run_words(96, 1, 1'b1);
    bare_commit();
    wait_drain();

    // stalled sink, both buffers end up occupied
    ready_mode = READY_HOLD;
    run_words(2 * pp_pkg::BLOCK_DEPTH, 0, 1'b0);
    @(negedge clk);
    check_value("o_wr_ready", widen_bit(1'b0), widen_bit(o_wr_ready));
    idle(8);
    ready_mode = READY_STALL;
    run_words(2, 0, 1'b0);
    bare_commit();
    wait_drain();

    // reset in the middle of a stream
    run_words(20, 0, 1'b0);
    apply_reset();
    repeat (2) check_idle_outputs();
    run_words(40, 1, 1'b1);
    bare_commit();
    wait_drain();

    // drained path is back to idle
    @(negedge clk);
    if (o_axis_valid || !o_wr_ready) begin
      $display("Stream path not idle after the last block drained");
      $display("Simulation finished: FAIL");
      $fatal(1, "stream path not idle");
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* sim.f */
logic/pp_pkg.sv
logic/ppfifo_rd_if.sv
logic/ping_pong_fifo.sv
logic/ppfifo_to_axis.sv
logic/stream_top.sv
verif/stream_checker.sv
verif/tb_stream_top.sv

/* Makefile */
# Verilator build and run for the stream path

VERILATOR ?= verilator
TOP       := tb_stream_top
RTL_TOP   := stream_top
FILELIST  := sim.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert --timescale 1ns/10ps -j 0
LINTFLAGS := --lint-only --timing --assert --timescale 1ns/10ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulation is the verdict
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
